// File: Bender.yml
package:
  name: lke_cam_stage

sources:
  - hdl/cam_lookup_pkg.sv
  - hdl/ctrl_table_writer.sv
  - hdl/cam_match_array.sv
  - hdl/lookup_ctrl.sv
  - hdl/lke_cam_stage.sv
  - target: test
    files:
      - test/cam_checker.sv
      - test/tb_lke_cam_stage.sv

// File: build.f
hdl/cam_lookup_pkg.sv
hdl/ctrl_table_writer.sv
hdl/cam_match_array.sv
hdl/lookup_ctrl.sv
hdl/lke_cam_stage.sv
test/cam_checker.sv
test/tb_lke_cam_stage.sv

// File: hdl/cam_lookup_pkg.sv
`default_nettype none

package cam_lookup_pkg;

    // ==================================================
    // Widths
    // ==================================================
    typedef logic [255:0]  ctrl_data_t;
    typedef logic [127:0]  ctrl_user_t;
    typedef logic [31:0]   ctrl_keep_t;
    typedef logic [1123:0] phv_t;
    typedef logic [196:0]  lookup_key_t;
    typedef logic [11:0]   vlan_id_t;
    typedef logic [204:0]  cam_entry_t;
    typedef logic [3:0]    cam_addr_t;
    typedef logic [7:0]    mod_id_t;

    // ==================================================
    // CAM and control header constants
    // ==================================================
    localparam int unsigned CAM_DEPTH = 16;
    localparam cam_addr_t   MISS_ADDR = '1;

    localparam logic [15:0] CTRL_FLAG_MAGIC = 16'hf2f1;

    // Field positions within the header beat
    localparam int unsigned MOD_ID_LSB    = 112;
    localparam int unsigned RESV_LSB      = 120;
    localparam int unsigned CTRL_FLAG_LSB = 64;
    localparam int unsigned INDEX_LSB     = 128;

    // Entry sits in the top bits once the beat is byte-reversed
    localparam int unsigned ENTRY_LSB = 51;

    // VLAN ID location in the PHV
    localparam int unsigned VLAN_LSB = 129;

    // ==================================================
    // State machines
    // ==================================================
    typedef enum logic [1:0] {idle, wait_result, halt} lookup_state_t;
    typedef enum logic [1:0] {first_beat, parse, entry, flush} ctrl_state_t;

endpackage

`default_nettype wire

// File: hdl/cam_match_array.sv
`timescale 1ns/100ps
`default_nettype none

module cam_match_array
    import cam_lookup_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wr_en,
    input  cam_addr_t   wr_addr,
    input  cam_entry_t  wr_entry,
    input  logic        key_valid,
    input  lookup_key_t extract_key,
    input  vlan_id_t    vlan_id,
    output logic        match,
    output cam_addr_t   match_addr
);

    cam_entry_t           mem [CAM_DEPTH];
    logic [CAM_DEPTH-1:0] entry_valid;
    logic [CAM_DEPTH-1:0] hit;
    cam_entry_t           lookup_word;
    cam_addr_t            hit_addr;

    logic [$bits(vlan_id_t)+$bits(lookup_key_t)-1:0] full_word;

    // Nibble-swapped VLAN ahead of the key, low bits kept to entry width
    assign full_word   = {vlan_id[3:0], vlan_id[11:4], extract_key};
    assign lookup_word = full_word[$bits(cam_entry_t)-1:0];

    // ==================================================
    // Storage
    // ==================================================
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_entry;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_valid <= '0;
        end else if (wr_en) begin
            entry_valid[wr_addr] <= 1'b1;
        end
    end

    // ==================================================
    // Compare and priority encode
    // ==================================================
    always_comb begin
        for (int i = 0; i < CAM_DEPTH; i++) begin
            hit[i] = entry_valid[i] && (mem[i] == lookup_word);
        end
    end

    // Scan downward so the lowest hit is the last one assigned
    always_comb begin
        hit_addr = MISS_ADDR;
        for (int i = CAM_DEPTH - 1; i >= 0; i--) begin
            if (hit[i]) begin
                hit_addr = cam_addr_t'(i);
            end
        end
    end

    // Result holds until the next key
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            match      <= 1'b0;
            match_addr <= MISS_ADDR;
        end else if (key_valid) begin
            match      <= |hit;
            match_addr <= hit_addr;
        end
    end

    a_wr_addr_known: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> !$isunknown(wr_addr));

endmodule

`default_nettype wire

// File: hdl/ctrl_table_writer.sv
`timescale 1ns/100ps
`default_nettype none

module ctrl_table_writer
    import cam_lookup_pkg::*;
#(
    parameter logic [4:0] stage_id  = 5'd0,
    parameter logic [2:0] lookup_id = 3'd2
) (
    input  logic       clk,
    input  logic       rst_n,
    input  ctrl_data_t c_s_axis_tdata,
    input  ctrl_user_t c_s_axis_tuser,
    input  ctrl_keep_t c_s_axis_tkeep,
    input  logic       c_s_axis_tvalid,
    input  logic       c_s_axis_tlast,
    output ctrl_data_t c_m_axis_tdata,
    output ctrl_user_t c_m_axis_tuser,
    output ctrl_keep_t c_m_axis_tkeep,
    output logic       c_m_axis_tvalid,
    output logic       c_m_axis_tlast,
    output logic       wr_en,
    output cam_addr_t  wr_addr,
    output cam_entry_t wr_entry
);

    ctrl_state_t state;

    // First beat, held until the header decides its fate
    ctrl_data_t first_data;
    ctrl_user_t first_user;
    ctrl_keep_t first_keep;
    logic       first_last;

    // Input delayed by one cycle for forwarding
    ctrl_data_t d1_data;
    ctrl_user_t d1_user;
    ctrl_keep_t d1_keep;
    logic       d1_valid;
    logic       d1_last;

    ctrl_data_t  swapped;
    mod_id_t     mod_id;
    logic [3:0]  resv;
    logic [15:0] ctrl_flag;
    logic        is_write;
    logic        emit_first;
    logic        emit_d1;
    logic        take_first;

    // ==================================================
    // Header decode on the second beat
    // ==================================================
    assign mod_id    = c_s_axis_tdata[MOD_ID_LSB +: $bits(mod_id_t)];
    assign resv      = c_s_axis_tdata[RESV_LSB +: 4];
    assign ctrl_flag = c_s_axis_tdata[CTRL_FLAG_LSB +: 16];

    assign is_write = (mod_id[7:3] == stage_id) && (mod_id[2:0] == lookup_id) &&
                      (ctrl_flag == CTRL_FLAG_MAGIC) && (resv == 4'd0);

    assign emit_first = (state == parse) && c_s_axis_tvalid && !is_write;
    assign emit_d1    = (state == flush);

    // A new packet may follow the last forwarded beat directly
    assign take_first = c_s_axis_tvalid &&
                        ((state == first_beat) || (emit_d1 && d1_valid && d1_last));

    // Little endian beat to big endian
    always_comb begin
        for (int i = 0; i < $bits(ctrl_keep_t); i++) begin
            swapped[8*i +: 8] = c_s_axis_tdata[8*($bits(ctrl_keep_t)-1-i) +: 8];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state           <= first_beat;
            wr_en           <= 1'b0;
            wr_addr         <= '0;
            d1_valid        <= 1'b0;
            c_m_axis_tvalid <= 1'b0;
            c_m_axis_tlast  <= 1'b0;
        end else begin
            d1_valid        <= c_s_axis_tvalid;
            wr_en           <= 1'b0;
            c_m_axis_tvalid <= emit_first || (emit_d1 && d1_valid);
            c_m_axis_tlast  <= emit_first ? first_last : (emit_d1 && d1_valid && d1_last);
            case (state)
                first_beat: begin
                    if (take_first) begin
                        state <= parse;
                    end
                end
                parse: begin
                    if (c_s_axis_tvalid && is_write) begin
                        wr_addr <= c_s_axis_tdata[INDEX_LSB +: $bits(cam_addr_t)];
                        state   <= entry;
                    end else if (c_s_axis_tvalid) begin
                        state <= flush;
                    end
                end
                entry: begin
                    if (c_s_axis_tvalid) begin
                        wr_en <= 1'b1;
                        state <= first_beat;
                    end
                end
                default: begin
                    if (d1_valid && d1_last) begin
                        state <= take_first ? parse : first_beat;
                    end
                end
            endcase
        end
    end

    // Payload path
    always_ff @(posedge clk) begin
        d1_data <= c_s_axis_tdata;
        d1_user <= c_s_axis_tuser;
        d1_keep <= c_s_axis_tkeep;
        d1_last <= c_s_axis_tlast;
        if (take_first) begin
            first_data <= c_s_axis_tdata;
            first_user <= c_s_axis_tuser;
            first_keep <= c_s_axis_tkeep;
            first_last <= c_s_axis_tlast;
        end
        if ((state == entry) && c_s_axis_tvalid) begin
            wr_entry <= swapped[ENTRY_LSB +: $bits(cam_entry_t)];
        end
        if (emit_first) begin
            c_m_axis_tdata <= first_data;
            c_m_axis_tuser <= first_user;
            c_m_axis_tkeep <= first_keep;
        end else if (emit_d1) begin
            c_m_axis_tdata <= d1_data;
            c_m_axis_tuser <= d1_user;
            c_m_axis_tkeep <= d1_keep;
        end
    end

    // One strobe per write packet
    a_single_wr: assert property (@(posedge clk) disable iff (!rst_n) wr_en |=> !wr_en);

endmodule

`default_nettype wire

// File: hdl/lke_cam_stage.sv
`timescale 1ns/100ps
`default_nettype none

module lke_cam_stage
    import cam_lookup_pkg::*;
#(
    parameter logic [4:0] stage_id  = 5'd0,
    parameter logic [2:0] lookup_id = 3'd2
) (
    input  logic        clk,
    input  logic        rst_n,
    // Lookup path
    input  lookup_key_t extract_key,
    input  logic        key_valid,
    input  phv_t        phv_in,
    output logic        ready_out,
    output phv_t        phv_out,
    output logic        phv_out_valid,
    output cam_addr_t   match_addr_out,
    output logic        if_match,
    input  logic        ready_in,
    // Control stream
    input  ctrl_data_t  c_s_axis_tdata,
    input  ctrl_user_t  c_s_axis_tuser,
    input  ctrl_keep_t  c_s_axis_tkeep,
    input  logic        c_s_axis_tvalid,
    input  logic        c_s_axis_tlast,
    output ctrl_data_t  c_m_axis_tdata,
    output ctrl_user_t  c_m_axis_tuser,
    output ctrl_keep_t  c_m_axis_tkeep,
    output logic        c_m_axis_tvalid,
    output logic        c_m_axis_tlast
);

    logic       wr_en;
    cam_addr_t  wr_addr;
    cam_entry_t wr_entry;
    vlan_id_t   vlan_id;
    logic       match;
    cam_addr_t  match_addr;

    assign vlan_id = phv_in[VLAN_LSB +: $bits(vlan_id_t)];

    ctrl_table_writer #(
        .stage_id  (stage_id),
        .lookup_id (lookup_id)
    ) i_writer (
        .clk             (clk),
        .rst_n           (rst_n),
        .c_s_axis_tdata  (c_s_axis_tdata),
        .c_s_axis_tuser  (c_s_axis_tuser),
        .c_s_axis_tkeep  (c_s_axis_tkeep),
        .c_s_axis_tvalid (c_s_axis_tvalid),
        .c_s_axis_tlast  (c_s_axis_tlast),
        .c_m_axis_tdata  (c_m_axis_tdata),
        .c_m_axis_tuser  (c_m_axis_tuser),
        .c_m_axis_tkeep  (c_m_axis_tkeep),
        .c_m_axis_tvalid (c_m_axis_tvalid),
        .c_m_axis_tlast  (c_m_axis_tlast),
        .wr_en           (wr_en),
        .wr_addr         (wr_addr),
        .wr_entry        (wr_entry)
    );

    cam_match_array i_cam (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_entry    (wr_entry),
        .key_valid   (key_valid),
        .extract_key (extract_key),
        .vlan_id     (vlan_id),
        .match       (match),
        .match_addr  (match_addr)
    );

    lookup_ctrl i_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .key_valid      (key_valid),
        .phv_in         (phv_in),
        .match          (match),
        .match_addr     (match_addr),
        .ready_in       (ready_in),
        .ready_out      (ready_out),
        .phv_out        (phv_out),
        .phv_out_valid  (phv_out_valid),
        .if_match       (if_match),
        .match_addr_out (match_addr_out)
    );

endmodule

`default_nettype wire

// File: hdl/lookup_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module lookup_ctrl
    import cam_lookup_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      key_valid,
    input  phv_t      phv_in,
    input  logic      match,
    input  cam_addr_t match_addr,
    input  logic      ready_in,
    output logic      ready_out,
    output phv_t      phv_out,
    output logic      phv_out_valid,
    output logic      if_match,
    output cam_addr_t match_addr_out
);

    lookup_state_t state;
    phv_t          phv_reg;
    logic          present;

    // Only one lookup in flight
    assign ready_out = (state == idle);

    // Result is presented from halt once downstream accepts
    assign present = (state == halt) && ready_in;

    // ==================================================
    // Stall FSM
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (key_valid) begin
                        state <= wait_result;
                    end
                end
                // CAM result registered on the key edge
                wait_result: begin
                    state <= halt;
                end
                default: begin
                    if (ready_in) begin
                        state <= idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phv_out_valid  <= 1'b0;
            if_match       <= 1'b0;
            match_addr_out <= '0;
        end else begin
            phv_out_valid <= present;
            if (present) begin
                if_match       <= match;
                match_addr_out <= match_addr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (key_valid) begin
            phv_reg <= phv_in;
        end
        if (present) begin
            phv_out <= phv_reg;
        end
    end

    // Upstream must respect ready_out
    a_key_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
        key_valid |-> state == idle);

endmodule

`default_nettype wire

// File: test/cam_checker.sv
`timescale 1ns/100ps
`default_nettype none

module cam_checker
    import cam_lookup_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       key_valid,
    input  logic       ready_in,
    input  logic       ready_out,
    input  phv_t       phv_out,
    input  logic       phv_out_valid,
    input  logic       if_match,
    input  cam_addr_t  match_addr_out,
    input  ctrl_data_t c_s_axis_tdata,
    input  ctrl_user_t c_s_axis_tuser,
    input  ctrl_keep_t c_s_axis_tkeep,
    input  logic       c_s_axis_tvalid,
    input  logic       c_s_axis_tlast,
    input  ctrl_data_t c_m_axis_tdata,
    input  ctrl_user_t c_m_axis_tuser,
    input  ctrl_keep_t c_m_axis_tkeep,
    input  logic       c_m_axis_tvalid,
    input  logic       c_m_axis_tlast,
    output int         error_count
);

    localparam int TIMEOUT = 64;

    // Beat packed as {last, keep, user, data}
    logic [416:0] beat_q [$];
    int           stamp_q [$];
    logic [416:0] exp_beat;
    int           exp_stamp;
    int           cycle = 0;
    int           keys = 0;
    int           pulses = 0;
    int           tests = 0;
    int           failed_tests = 0;
    int           errors_at_start = 0;
    logic         fwd_on = 1'b0;

    initial begin
        error_count = 0;
    end

    task automatic fail_value(input string name, input logic [1123:0] exp,
                              input logic [1123:0] act);
        $display("error at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
        error_count++;
    endtask

    task automatic note_failure(input string what);
        $display("at %0t ns: %s", $time, what);
        error_count++;
    endtask

    task automatic start_test();
        errors_at_start = error_count;
    endtask

    task automatic end_test(input string name);
        tests++;
        if (error_count == errors_at_start) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: %0d errors", tests, name, error_count - errors_at_start);
        end
    endtask

    task automatic expect_forward(input logic on);
        fwd_on = on;
    endtask

    task automatic check_reset_values();
        if (phv_out_valid !== 1'b0) fail_value("phv_out_valid", 0, phv_out_valid);
        if (if_match !== 1'b0) fail_value("if_match", 0, if_match);
        if (match_addr_out !== '0) fail_value("match_addr_out", 0, match_addr_out);
        if (ready_out !== 1'b1) fail_value("ready_out", 1, ready_out);
        if (c_m_axis_tvalid !== 1'b0) fail_value("c_m_axis_tvalid", 0, c_m_axis_tvalid);
        if (c_m_axis_tlast !== 1'b0) fail_value("c_m_axis_tlast", 0, c_m_axis_tlast);
    endtask

    // ==================================================
    // Lookup result, called just before the key edge
    // ==================================================
    task automatic check_lookup(input logic exp_hit, input cam_addr_t exp_addr,
                                input phv_t exp_phv);
        int   waited;
        logic seen;
        logic late;
        logic last_ready;
        waited     = 0;
        seen       = 1'b0;
        late       = 1'b0;
        last_ready = 1'b0;
        @(posedge clk);
        while (!seen && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
            // Earliest pulse is seen 3 samples after the key edge
            if (phv_out_valid) begin
                seen = 1'b1;
                if (!last_ready || waited < 3) begin
                    note_failure("phv_out_valid pulsed before ready_in was seen in halt");
                end
            end else begin
                if (ready_out) note_failure("ready_out went high before the result pulse");
                if (last_ready && waited >= 3 && !late) begin
                    late = 1'b1;
                    note_failure("phv_out_valid missing one cycle after ready_in was high");
                end
            end
            last_ready = ready_in;
        end
        if (!seen) begin
            note_failure("timeout waiting for phv_out_valid");
        end else begin
            if (if_match !== exp_hit) fail_value("if_match", exp_hit, if_match);
            if (match_addr_out !== exp_addr) fail_value("match_addr_out", exp_addr, match_addr_out);
            if (phv_out !== exp_phv) fail_value("phv_out", exp_phv, phv_out);
            @(posedge clk);
            if (phv_out_valid) note_failure("second phv_out_valid pulse for one key");
            if (if_match !== exp_hit || match_addr_out !== exp_addr || phv_out !== exp_phv) begin
                note_failure("lookup result changed after the pulse");
            end
        end
    endtask

    task automatic wait_forward_drain();
        int waited;
        waited = 0;
        while (beat_q.size() != 0 && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (beat_q.size() != 0) note_failure("timeout waiting for forwarded beats");
    endtask

    // ==================================================
    // Control stream monitor
    // ==================================================
    always @(posedge clk) begin
        if (rst_n) begin
            if (key_valid) keys++;
            if (phv_out_valid) pulses++;
            if (c_s_axis_tvalid && fwd_on) begin
                beat_q.push_back({c_s_axis_tlast, c_s_axis_tkeep, c_s_axis_tuser, c_s_axis_tdata});
                stamp_q.push_back(cycle);
            end
            if (c_m_axis_tvalid) begin
                if (beat_q.size() == 0) begin
                    note_failure("beat on c_m_axis with no forwarded input beat");
                end else begin
                    exp_beat  = beat_q.pop_front();
                    exp_stamp = stamp_q.pop_front();
                    if (c_m_axis_tdata !== exp_beat[255:0])
                        fail_value("c_m_axis_tdata", exp_beat[255:0], c_m_axis_tdata);
                    if (c_m_axis_tuser !== exp_beat[383:256])
                        fail_value("c_m_axis_tuser", exp_beat[383:256], c_m_axis_tuser);
                    if (c_m_axis_tkeep !== exp_beat[415:384])
                        fail_value("c_m_axis_tkeep", exp_beat[415:384], c_m_axis_tkeep);
                    if (c_m_axis_tlast !== exp_beat[416])
                        fail_value("c_m_axis_tlast", exp_beat[416], c_m_axis_tlast);
                    if (cycle != exp_stamp + 2)
                        note_failure($sformatf("forwarded beat took %0d cycles, not 2",
                                               cycle - exp_stamp));
                end
            end
        end
        cycle++;
    end

    task automatic report();
        if (keys != pulses) note_failure($sformatf("%0d keys but %0d pulses", keys, pulses));
        if (beat_q.size() != 0) note_failure("forwarded beats still missing at the end");
        $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, error_count);
    endtask

endmodule

`default_nettype wire

// File: test/lookup_cases.txt
// cmd a0 a1 a2 a3 a4 in hex. 1 write: index vlan key 0 0. 2 lookup: 0 vlan key hit addr
// 3 forward: beats mod_id flag reserved index. A line with cmd 0 ends the list
2 0 123 abcdef0123 0 f
2 0 000 0 0 f
1 3 5a1 0badc0ffee0001 0 0
1 7 0c4 1234567890abcdef 0 0
1 0 fff 10123456789abcdef0123456789abcdef0123456789abcdef5 0 0
2 0 5a1 0badc0ffee0001 1 3
2 0 0c4 1234567890abcdef 1 7
2 0 fff 10123456789abcdef0123456789abcdef0123456789abcdef5 1 0
2 0 6a1 0badc0ffee0001 0 f
2 0 0c4 1234567890abcdee 0 f
1 9 5a1 0badc0ffee0001 0 0
2 0 5a1 0badc0ffee0001 1 3
1 e 2b6 55aa55aa 0 0
1 c 2b6 55aa55aa 0 0
2 0 2b6 55aa55aa 1 c
3 3 0a f2f1 0 5
3 4 13 f2f1 0 5
3 3 12 f2f0 0 5
3 5 12 f2f1 8 5
2 0 777 777 0 f
1 5 777 777 0 0
2 0 777 777 1 5
0 0 0 0 0 0

// File: test/tb_lke_cam_stage.sv
`timescale 1ns/100ps
`default_nettype none

module tb_lke_cam_stage
    import cam_lookup_pkg::*;
();

    localparam int          CASE_WORDS = 6;
    localparam int          MAX_CASES  = 40;
    localparam int          TIMEOUT    = 64;
    localparam int unsigned SEED       = 32'h2136_7c45;
    localparam logic [4:0]  STAGE_ID   = 5'd2;
    localparam logic [2:0]  LOOKUP_ID  = 3'd2;
    localparam vlan_id_t    PROBE_VLAN = 12'h777;
    localparam lookup_key_t PROBE_KEY  = 197'h777;

    logic        clk;
    logic        rst_n;
    lookup_key_t extract_key;
    logic        key_valid;
    phv_t        phv_in;
    logic        ready_in;
    logic        ready_out;
    phv_t        phv_out;
    logic        phv_out_valid;
    cam_addr_t   match_addr_out;
    logic        if_match;
    ctrl_data_t  c_s_axis_tdata;
    ctrl_user_t  c_s_axis_tuser;
    ctrl_keep_t  c_s_axis_tkeep;
    logic        c_s_axis_tvalid;
    logic        c_s_axis_tlast;
    ctrl_data_t  c_m_axis_tdata;
    ctrl_user_t  c_m_axis_tuser;
    ctrl_keep_t  c_m_axis_tkeep;
    logic        c_m_axis_tvalid;
    logic        c_m_axis_tlast;
    int          error_count;

    logic [255:0] cases [CASE_WORDS*MAX_CASES];

    lke_cam_stage #(
        .stage_id  (STAGE_ID),
        .lookup_id (LOOKUP_ID)
    ) i_dut (
        .clk (clk), .rst_n (rst_n),
        .extract_key (extract_key), .key_valid (key_valid), .phv_in (phv_in),
        .ready_out (ready_out), .phv_out (phv_out), .phv_out_valid (phv_out_valid),
        .match_addr_out (match_addr_out), .if_match (if_match), .ready_in (ready_in),
        .c_s_axis_tdata (c_s_axis_tdata), .c_s_axis_tuser (c_s_axis_tuser),
        .c_s_axis_tkeep (c_s_axis_tkeep), .c_s_axis_tvalid (c_s_axis_tvalid),
        .c_s_axis_tlast (c_s_axis_tlast),
        .c_m_axis_tdata (c_m_axis_tdata), .c_m_axis_tuser (c_m_axis_tuser),
        .c_m_axis_tkeep (c_m_axis_tkeep), .c_m_axis_tvalid (c_m_axis_tvalid),
        .c_m_axis_tlast (c_m_axis_tlast)
    );

    cam_checker i_checker (
        .clk (clk), .rst_n (rst_n), .key_valid (key_valid), .ready_in (ready_in),
        .ready_out (ready_out), .phv_out (phv_out), .phv_out_valid (phv_out_valid),
        .if_match (if_match), .match_addr_out (match_addr_out),
        .c_s_axis_tdata (c_s_axis_tdata), .c_s_axis_tuser (c_s_axis_tuser),
        .c_s_axis_tkeep (c_s_axis_tkeep), .c_s_axis_tvalid (c_s_axis_tvalid),
        .c_s_axis_tlast (c_s_axis_tlast),
        .c_m_axis_tdata (c_m_axis_tdata), .c_m_axis_tuser (c_m_axis_tuser),
        .c_m_axis_tkeep (c_m_axis_tkeep), .c_m_axis_tvalid (c_m_axis_tvalid),
        .c_m_axis_tlast (c_m_axis_tlast), .error_count (error_count)
    );

    always #20 clk = ~clk;

    // ==================================================
    // Stimulus helpers
    // ==================================================
    function automatic logic [1151:0] random_wide();
        logic [1151:0] bits;
        bits = '0;
        for (int i = 0; i < 36; i++) begin
            bits = {bits[1119:0], $urandom};
        end
        return bits;
    endfunction

    function automatic phv_t random_phv(input vlan_id_t vlan);
        phv_t p;
        p = phv_t'(random_wide());
        p[VLAN_LSB +: $bits(vlan_id_t)] = vlan;
        return p;
    endfunction

    // Low VLAN nibble, high VLAN byte, then key, cut to entry width
    function automatic cam_entry_t entry_word(input vlan_id_t vlan, input lookup_key_t key);
        logic [$bits(vlan_id_t)+$bits(lookup_key_t)-1:0] full;
        full = {vlan[3:0], vlan[11:4], key};
        return full[$bits(cam_entry_t)-1:0];
    endfunction

    function automatic ctrl_data_t byte_reverse(input ctrl_data_t d);
        ctrl_data_t r;
        for (int i = 0; i < 32; i++) begin
            r[8*i +: 8] = d[8*(31-i) +: 8];
        end
        return r;
    endfunction

    task automatic send_packet(input int beats, input mod_id_t mod_id, input logic [15:0] flag,
                               input logic [3:0] resv, input cam_addr_t index,
                               input cam_entry_t ent);
        ctrl_data_t data;
        for (int b = 0; b < beats; b++) begin
            data = ctrl_data_t'(random_wide());
            if (b == 1) begin
                data[MOD_ID_LSB +: 8]     = mod_id;
                data[RESV_LSB +: 4]       = resv;
                data[CTRL_FLAG_LSB +: 16] = flag;
                data[INDEX_LSB +: 4]      = index;
            end else if (b == 2) begin
                data = byte_reverse({ent, data[ENTRY_LSB-1:0]});
            end
            @(negedge clk);
            c_s_axis_tdata  = data;
            c_s_axis_tuser  = ctrl_user_t'(random_wide());
            c_s_axis_tkeep  = $urandom;
            c_s_axis_tvalid = 1'b1;
            c_s_axis_tlast  = (b == beats - 1);
        end
        @(negedge clk);
        c_s_axis_tvalid = 1'b0;
        c_s_axis_tlast  = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    task automatic do_lookup(input vlan_id_t vlan, input lookup_key_t key, input logic exp_hit,
                             input cam_addr_t exp_addr);
        phv_t phv;
        int   gap;
        int   waited;
        waited = 0;
        @(negedge clk);
        while (!ready_out && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!ready_out) begin
            i_checker.note_failure("timeout waiting for ready_out");
        end else begin
            phv         = random_phv(vlan);
            gap         = $urandom_range(0, 6);
            extract_key = key;
            phv_in      = phv;
            key_valid   = 1'b1;
            ready_in    = (gap == 0);
            fork
                i_checker.check_lookup(exp_hit, exp_addr, phv);
                begin
                    @(negedge clk);
                    key_valid = 1'b0;
                    phv_in    = random_phv(vlan);
                    repeat (gap) @(negedge clk);
                    ready_in = 1'b1;
                end
            join
        end
    endtask

    task automatic run_case(input int n);
        logic [255:0] cmd;
        logic [255:0] a [5];
        string        name;
        cmd = cases[CASE_WORDS*n];
        for (int i = 0; i < 5; i++) begin
            a[i] = cases[CASE_WORDS*n + 1 + i];
        end
        i_checker.start_test();
        case (cmd[1:0])
            2'd1: begin
                name = $sformatf("write index %0d vlan %03h", a[0][3:0], a[1][11:0]);
                send_packet(3, {STAGE_ID, LOOKUP_ID}, CTRL_FLAG_MAGIC, 4'd0, a[0][3:0],
                            entry_word(a[1][11:0], a[2][196:0]));
            end
            2'd2: begin
                name = $sformatf("lookup vlan %03h hit %0d", a[1][11:0], a[3][0]);
                do_lookup(a[1][11:0], a[2][196:0], a[3][0], a[4][3:0]);
            end
            default: begin
                name = $sformatf("forward %0d beats mod_id %02h", a[0], a[1][7:0]);
                i_checker.expect_forward(1'b1);
                send_packet(a[0], a[1][7:0], a[2][15:0], a[3][3:0], a[4][3:0],
                            entry_word(PROBE_VLAN, PROBE_KEY));
                i_checker.wait_forward_drain();
                i_checker.expect_forward(1'b0);
            end
        endcase
        i_checker.end_test(name);
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        int           seeded;
        logic [255:0] cmd;
        logic         known;
        seeded          = $urandom(SEED);
        clk             = 1'b0;
        rst_n           = 1'b0;
        extract_key     = '0;
        key_valid       = 1'b0;
        phv_in          = '0;
        ready_in        = 1'b1;
        c_s_axis_tdata  = '0;
        c_s_axis_tuser  = '0;
        c_s_axis_tkeep  = '0;
        c_s_axis_tvalid = 1'b0;
        c_s_axis_tlast  = 1'b0;
        $readmemh("test/lookup_cases.txt", cases);
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        i_checker.start_test();
        i_checker.check_reset_values();
        i_checker.end_test("reset values");
        for (int n = 0; n < MAX_CASES; n++) begin
            cmd   = cases[CASE_WORDS*n];
            known = (cmd === 256'd1) || (cmd === 256'd2) || (cmd === 256'd3);
            if (!known) break;
            run_case(n);
        end
        i_checker.report();
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
